/* common/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

`define CACHE_WAYS   4
`define CACHE_SETS   16
`define LINE_BYTES   32
`define ADDR_BITS    32
`define WORD_BITS    32

// derived field widths
`define LINE_BITS    (`LINE_BYTES * 8)
`define OFFSET_BITS  $clog2(`LINE_BYTES)
`define SET_BITS     $clog2(`CACHE_SETS)
`define WAY_BITS     $clog2(`CACHE_WAYS)
`define TAG_BITS     (`ADDR_BITS - `SET_BITS - `OFFSET_BITS)
`define WORD_BYTES   (`WORD_BITS / 8)
`define WSEL_LO      $clog2(`WORD_BYTES)   // low bit of word select
`define PLRU_BITS    (`CACHE_WAYS - 1)

`endif

/* common/cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`ADDR_BITS-1:0]  addr_t;
    typedef logic [`WORD_BITS-1:0]  word_t;
    typedef logic [`LINE_BITS-1:0]  line_t;
    typedef logic [`TAG_BITS-1:0]   tag_t;
    typedef logic [`SET_BITS-1:0]   set_t;
    typedef logic [`WAY_BITS-1:0]   way_t;
    typedef logic [`WORD_BYTES-1:0] bmask_t;
    typedef logic [`PLRU_BITS-1:0]  plru_t;

    // one request in flight, no pipeline
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL
    } cache_state_t;

endpackage

/* common/cache_array_if.sv */
interface cache_array_if;

    cache_pkg::addr_t  addr;

    // lookup results, one cycle after addr
    logic              hit;
    cache_pkg::way_t   hit_way;
    cache_pkg::line_t  hit_line;
    logic              victim_dirty;
    cache_pkg::tag_t   victim_tag;
    cache_pkg::line_t  victim_line;

    logic              write_word;  // merge into hit way
    cache_pkg::word_t  wdata;
    cache_pkg::bmask_t wmask;
    logic              fill;        // install into victim way
    cache_pkg::line_t  fill_line;

    modport ctrl (
        output addr, write_word, wdata, wmask, fill, fill_line,
        input  hit, hit_way, hit_line, victim_dirty, victim_tag, victim_line
    );

    modport store (
        input  addr, write_word, wdata, wmask, fill, fill_line,
        output hit, hit_way, hit_line, victim_dirty, victim_tag, victim_line
    );

endinterface

/* cache/plru_tree.sv */
`include "cache_defines.svh"

module plru_tree (
    input  logic            clk,
    input  logic            rst,
    input  cache_pkg::set_t set,
    input  logic            touch,
    input  cache_pkg::way_t touch_way,
    output cache_pkg::way_t plru_way
);

    cache_pkg::plru_t tree [`CACHE_SETS];
    cache_pkg::set_t  set_q;
    cache_pkg::plru_t cur;

    always_ff @(posedge clk) begin
        set_q <= set;
    end

    // bit 0 picks the half, then that half's bit picks the way
    assign cur      = tree[set_q];
    assign plru_way = {cur[0], (cur[0] ? cur[2] : cur[1])};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[set_q][0] <= ~touch_way[1];   // other half
            if (touch_way[1]) begin
                tree[set_q][2] <= ~touch_way[0];
            end else begin
                tree[set_q][1] <= ~touch_way[0];
            end
        end
    end

endmodule

/* cache/cache_ways.sv */
`include "cache_defines.svh"

module cache_ways (
    input  logic            clk,
    input  logic            rst,
    cache_array_if.store    arr,
    input  cache_pkg::way_t plru_way
);

    cache_pkg::tag_t        tag_mem   [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::line_t       data_mem  [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] valid_mem [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] dirty_mem [`CACHE_SETS];

    cache_pkg::addr_t       addr_q;
    cache_pkg::tag_t        tag_q;
    cache_pkg::set_t        set_q;
    logic [`OFFSET_BITS-`WSEL_LO-1:0] wsel_q;
    logic [`CACHE_WAYS-1:0] way_hit;
    cache_pkg::way_t        victim_way;
    cache_pkg::line_t       merged_line;

    // read address registered, arrays read combinationally after it
    always_ff @(posedge clk) begin
        addr_q <= arr.addr;
    end

    assign tag_q  = addr_q[`ADDR_BITS-1 -: `TAG_BITS];
    assign set_q  = addr_q[`OFFSET_BITS +: `SET_BITS];
    assign wsel_q = addr_q[`WSEL_LO +: (`OFFSET_BITS - `WSEL_LO)];

    always_comb begin
        arr.hit_way = '0;
        victim_way  = plru_way;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = valid_mem[set_q][w] && (tag_mem[set_q][w] == tag_q);
            if (way_hit[w]) begin
                arr.hit_way = cache_pkg::way_t'(w);
            end
        end
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_mem[set_q][w]) begin
                victim_way = cache_pkg::way_t'(w);   // lowest invalid wins
            end
        end
    end

    assign arr.hit          = |way_hit;
    assign arr.hit_line     = data_mem[set_q][arr.hit_way];
    assign arr.victim_tag   = tag_mem[set_q][victim_way];
    assign arr.victim_line  = data_mem[set_q][victim_way];
    assign arr.victim_dirty = valid_mem[set_q][victim_way] && dirty_mem[set_q][victim_way];

    always_comb begin
        merged_line = data_mem[set_q][arr.hit_way];
        for (int b = 0; b < `WORD_BYTES; b++) begin
            if (arr.wmask[b]) begin
                merged_line[wsel_q * `WORD_BITS + b * 8 +: 8] = arr.wdata[b * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
        end else if (arr.fill) begin
            valid_mem[set_q][victim_way] <= 1'b1;
            dirty_mem[set_q][victim_way] <= 1'b0;   // fresh from memory
        end else if (arr.write_word) begin
            dirty_mem[set_q][arr.hit_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (arr.fill) begin
            tag_mem[set_q][victim_way]  <= tag_q;
            data_mem[set_q][victim_way] <= arr.fill_line;
        end else if (arr.write_word) begin
            data_mem[set_q][arr.hit_way] <= merged_line;
        end
    end

endmodule

/* cache/cache_ctrl.sv */
`include "cache_defines.svh"

module cache_ctrl (
    input  logic              clk,
    input  logic              rst,

    input  cache_pkg::addr_t  ufp_addr,
    input  cache_pkg::bmask_t ufp_rmask,
    input  cache_pkg::bmask_t ufp_wmask,
    input  cache_pkg::word_t  ufp_wdata,
    output cache_pkg::word_t  ufp_rdata,
    output logic              ufp_resp,

    output cache_pkg::addr_t  dfp_addr,
    output logic              dfp_read,
    output logic              dfp_write,
    input  cache_pkg::line_t  dfp_rdata,
    output cache_pkg::line_t  dfp_wdata,
    input  logic              dfp_resp,

    cache_array_if.ctrl       arr,

    output logic              touch,
    output cache_pkg::way_t   touch_way
);

    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t state_next;

    logic                   request;
    cache_pkg::tag_t        req_tag;
    cache_pkg::set_t        req_set;
    logic [`OFFSET_BITS-`WSEL_LO-1:0] req_wsel;

    assign request  = (ufp_rmask != '0) || (ufp_wmask != '0);
    assign req_tag  = ufp_addr[`ADDR_BITS-1 -: `TAG_BITS];
    assign req_set  = ufp_addr[`OFFSET_BITS +: `SET_BITS];
    assign req_wsel = ufp_addr[`WSEL_LO +: (`OFFSET_BITS - `WSEL_LO)];

    // request fields go straight to the arrays, held by the cpu
    assign arr.addr      = ufp_addr;
    assign arr.wdata     = ufp_wdata;
    assign arr.wmask     = ufp_wmask;
    assign arr.fill_line = dfp_rdata;

    assign ufp_rdata = arr.hit_line[req_wsel * `WORD_BITS +: `WORD_BITS];
    assign dfp_wdata = arr.victim_line;
    assign touch_way = arr.hit_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next     = state;
        ufp_resp       = 1'b0;
        dfp_read       = 1'b0;
        dfp_write      = 1'b0;
        dfp_addr       = {req_tag, req_set, {`OFFSET_BITS{1'b0}}};
        arr.write_word = 1'b0;
        arr.fill       = 1'b0;
        touch          = 1'b0;

        unique case (state)
            cache_pkg::IDLE: begin
                if (request) begin
                    state_next = cache_pkg::LOOKUP;   // arrays read this cycle
                end
            end
            cache_pkg::LOOKUP: begin
                if (arr.hit) begin
                    ufp_resp       = 1'b1;
                    arr.write_word = (ufp_wmask != '0);
                    touch          = 1'b1;
                    state_next     = cache_pkg::IDLE;
                end else if (arr.victim_dirty) begin
                    state_next = cache_pkg::WRITEBACK;
                end else begin
                    state_next = cache_pkg::FILL;
                end
            end
            cache_pkg::WRITEBACK: begin
                dfp_write = 1'b1;
                dfp_addr  = {arr.victim_tag, req_set, {`OFFSET_BITS{1'b0}}};
                if (dfp_resp) begin
                    state_next = cache_pkg::FILL;
                end
            end
            cache_pkg::FILL: begin
                dfp_read = 1'b1;
                if (dfp_resp) begin
                    arr.fill   = 1'b1;
                    state_next = cache_pkg::LOOKUP;   // hits next cycle, arrays write-first
                end
            end
            default: begin
                state_next = cache_pkg::IDLE;
            end
        endcase
    end

endmodule

/* cache/cache.sv */
`include "cache_defines.svh"

module cache (
    input  logic              clk,
    input  logic              rst,

    // cpu side
    input  cache_pkg::addr_t  ufp_addr,
    input  cache_pkg::bmask_t ufp_rmask,
    input  cache_pkg::bmask_t ufp_wmask,
    input  cache_pkg::word_t  ufp_wdata,
    output cache_pkg::word_t  ufp_rdata,
    output logic              ufp_resp,

    // memory side, whole lines
    output cache_pkg::addr_t  dfp_addr,
    output logic              dfp_read,
    output logic              dfp_write,
    input  cache_pkg::line_t  dfp_rdata,
    output cache_pkg::line_t  dfp_wdata,
    input  logic              dfp_resp
);

    logic            touch;
    cache_pkg::way_t touch_way;
    cache_pkg::way_t plru_way;

    cache_array_if arr ();

    cache_ctrl ctrl (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_wdata (ufp_wdata),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_rdata (dfp_rdata),
        .dfp_wdata (dfp_wdata),
        .dfp_resp  (dfp_resp),
        .arr       (arr.ctrl),
        .touch     (touch),
        .touch_way (touch_way)
    );

    cache_ways ways (
        .clk      (clk),
        .rst      (rst),
        .arr      (arr.store),
        .plru_way (plru_way)
    );

    plru_tree plru (
        .clk       (clk),
        .rst       (rst),
        .set       (arr.addr[`OFFSET_BITS +: `SET_BITS]),   // same set the arrays read
        .touch     (touch),
        .touch_way (touch_way),
        .plru_way  (plru_way)
    );

endmodule

/* testbench/tb_clock.sv */
module tb_clock #(
    parameter int period = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

/* testbench/cache_sva.sv */
module cache_sva (
    input logic             clk,
    input logic             rst,
    input logic             ufp_resp,
    input logic             dfp_read,
    input logic             dfp_write,
    input logic             dfp_resp,
    input cache_pkg::addr_t dfp_addr,
    input cache_pkg::line_t dfp_wdata
);

    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write))
        else $error("dfp_read and dfp_write high together");

    resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |=> !ufp_resp)
        else $error("ufp_resp held longer than one cycle");

    // memory requests wait for dfp_resp without changing
    read_held: assert property (@(posedge clk) disable iff (rst)
        dfp_read && !dfp_resp |=> dfp_read && $stable(dfp_addr))
        else $error("dfp_read dropped or address changed before dfp_resp");

    write_held: assert property (@(posedge clk) disable iff (rst)
        dfp_write && !dfp_resp |=> dfp_write && $stable(dfp_addr) && $stable(dfp_wdata))
        else $error("dfp_write dropped or address or data changed before dfp_resp");

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !ufp_resp && !dfp_read && !dfp_write)
        else $error("outputs not low after reset");

endmodule

bind cache cache_sva sva (
    .clk       (clk),
    .rst       (rst),
    .ufp_resp  (ufp_resp),
    .dfp_read  (dfp_read),
    .dfp_write (dfp_write),
    .dfp_resp  (dfp_resp),
    .dfp_addr  (dfp_addr),
    .dfp_wdata (dfp_wdata)
);

/* testbench/cache_tb.sv */
`include "cache_defines.svh"

module cache_tb;

    localparam int period     = 8;
    localparam int max_delay  = 3;
    localparam int total_reqs = 254;
    // idle, lookup, write-back and fill with their waits, lookup, release
    localparam int worst_miss = 2 * (max_delay + 2) + 4;

    logic              clk;
    logic              rst;
    cache_pkg::addr_t  ufp_addr;
    cache_pkg::bmask_t ufp_rmask;
    cache_pkg::bmask_t ufp_wmask;
    cache_pkg::word_t  ufp_wdata;
    cache_pkg::word_t  ufp_rdata;
    logic              ufp_resp;
    cache_pkg::addr_t  dfp_addr;
    logic              dfp_read;
    logic              dfp_write;
    cache_pkg::line_t  dfp_rdata;
    cache_pkg::line_t  dfp_wdata;
    logic              dfp_resp;

    cache_pkg::line_t  mem [cache_pkg::addr_t];        // lines written back
    logic [7:0]        ref_bytes [cache_pkg::addr_t];  // every cpu write
    logic [32:0]       ops [$];                        // {is_write, line address}
    int                delays [64];
    int                n_served = 0;
    int                resp_count = 0;
    int                errors = 0;
    int                checks = 0;

    tb_clock #(.period(period)) clock_gen (.clk(clk));

    cache uut (.*);

    function automatic cache_pkg::word_t init_word(cache_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[31:16]};
    endfunction

    function automatic logic [7:0] ref_byte(cache_pkg::addr_t a);
        cache_pkg::word_t w;
        if (ref_bytes.exists(a)) begin
            return ref_bytes[a];
        end
        w = init_word({a[31:2], 2'b00});
        return w[a[1:0] * 8 +: 8];
    endfunction

    function automatic cache_pkg::line_t ref_line(cache_pkg::addr_t la);
        cache_pkg::line_t l;
        for (int i = 0; i < `LINE_BYTES; i++) begin
            l[i * 8 +: 8] = ref_byte(la + i);
        end
        return l;
    endfunction

    function automatic cache_pkg::line_t mem_line(cache_pkg::addr_t la);
        cache_pkg::line_t l;
        if (mem.exists(la)) begin
            return mem[la];
        end
        for (int k = 0; k < `LINE_BYTES / `WORD_BYTES; k++) begin
            l[k * `WORD_BITS +: `WORD_BITS] = init_word(la + k * `WORD_BYTES);
        end
        return l;
    endfunction

    function automatic cache_pkg::addr_t line_addr(input int t, input int s);
        return {cache_pkg::tag_t'(t), cache_pkg::set_t'(s), {`OFFSET_BITS{1'b0}}};
    endfunction

    initial begin : memory_model
        cache_pkg::addr_t la;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(negedge clk);
            dfp_resp = 1'b0;
            if (!rst && (dfp_read || dfp_write)) begin
                repeat (delays[n_served % 64]) @(negedge clk);
                n_served++;
                la = dfp_addr;
                ops.push_back({dfp_write, la});
                if (dfp_write) begin
                    checks++;
                    if (dfp_wdata !== ref_line(la)) begin
                        errors++;
                        $display("CHECK FAILED t=%0t dfp_wdata got %h expected %h",
                                 $time, dfp_wdata, ref_line(la));
                    end
                    mem[la] = dfp_wdata;
                end else begin
                    dfp_rdata = mem_line(la);
                end
                dfp_resp = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (ufp_resp === 1'b1) begin
            resp_count++;
        end
    end

    initial begin : watchdog
        #((8 + total_reqs * worst_miss) * period);
        $display("timeout: a request got no response in time");
        $display("Errors found");
        $finish;
    end

    // called at a falling edge, returns at one with the masks cleared
    task automatic access(input cache_pkg::addr_t a, input cache_pkg::bmask_t rm,
                          input cache_pkg::bmask_t wm, input cache_pkg::word_t wd,
                          output int lat);
        cache_pkg::word_t expected;
        ufp_addr  = a;
        ufp_rmask = rm;
        ufp_wmask = wm;
        ufp_wdata = wd;
        lat = 1;
        for (int b = 0; b < `WORD_BYTES; b++) begin
            expected[b * 8 +: 8] = ref_byte({a[31:2], 2'b00} + b);
        end
        do begin
            @(negedge clk);
            lat++;
        end while (ufp_resp !== 1'b1);
        if (wm == '0) begin
            checks++;
            if (ufp_rdata !== expected) begin
                errors++;
                $display("CHECK FAILED t=%0t ufp_rdata got %h expected %h",
                         $time, ufp_rdata, expected);
            end
        end
        for (int b = 0; b < `WORD_BYTES; b++) begin
            if (wm[b]) begin
                ref_bytes[{a[31:2], 2'b00} + b] = wd[b * 8 +: 8];
            end
        end
        @(negedge clk);
        ufp_rmask = '0;
        ufp_wmask = '0;
    endtask

    task automatic check_ops(input logic wb, input cache_pkg::addr_t victim,
                             input cache_pkg::addr_t fill);
        logic bad;
        if (wb) begin
            bad = ops.size() != 2 || ops[0] !== {1'b1, victim} || ops[1] !== {1'b0, fill};
        end else begin
            bad = ops.size() != 1 || ops[0] !== {1'b0, fill};
        end
        checks++;
        if (bad) begin
            errors++;
            $display("t=%0t memory traffic wrong, expected write-back %0d of %h, fill of %h",
                     $time, wb, victim, fill);
        end
    endtask

    task automatic report(input string name, input int errors_before);
        $display("%-20s %0d errors", name, errors - errors_before);
    endtask

    task automatic read_miss_then_hit();
        int e0;
        int lat;
        e0 = errors;
        access(32'h0000_1234, 4'hf, 4'h0, '0, lat);
        access(32'h0000_1234, 4'hf, 4'h0, '0, lat);
        checks++;
        if (lat != 2) begin
            errors++;
            $display("CHECK FAILED t=%0t ufp_resp cycle got %0d expected %0d", $time, lat, 2);
        end
        report("read_miss_then_hit", e0);
    endtask

    task automatic masked_write_hits();
        int e0;
        int lat;
        e0 = errors;
        access(32'h0000_2048, 4'hf, 4'h0, '0, lat);
        for (int m = 0; m < 16; m++) begin
            // mask 0 still needs a request, so it goes out as a read
            access(32'h0000_2048, (m == 0) ? 4'h1 : 4'h0, 4'(m),
                   32'h1234_5678 ^ (m * 32'h1111_1111), lat);
            access(32'h0000_2048, 4'hf, 4'h0, '0, lat);
        end
        report("masked_write_hits", e0);
    endtask

    task automatic dirty_writeback();
        int e0;
        int lat;
        e0 = errors;
        for (int t = 1; t <= 4; t++) begin
            access(line_addr(t, 5) + 4, 4'h0, 4'hf, 32'hd00d_0000 + t, lat);
        end
        ops.delete();
        // fills touched ways 0 to 3 in turn, tree points back at way 0
        access(line_addr(5, 5), 4'hf, 4'h0, '0, lat);
        check_ops(1'b1, line_addr(1, 5), line_addr(5, 5));
        for (int t = 1; t <= 4; t++) begin
            access(line_addr(t, 6), 4'hf, 4'h0, '0, lat);
        end
        ops.delete();
        access(line_addr(5, 6), 4'hf, 4'h0, '0, lat);
        check_ops(1'b0, '0, line_addr(5, 6));
        report("dirty_writeback", e0);
    endtask

    task automatic plru_victim();
        int e0;
        int lat;
        int order [4] = '{1, 3, 4, 2};   // ways 0, 2, 3, 1
        e0 = errors;
        for (int t = 1; t <= 4; t++) begin
            access(line_addr(t, 9), 4'h0, 4'h3, 32'hbeef_0000 + t, lat);
        end
        foreach (order[i]) begin
            access(line_addr(order[i], 9), 4'hf, 4'h0, '0, lat);
        end
        // tree ends at 0b001, pointer way 2 although way 0 is the oldest
        ops.delete();
        access(line_addr(5, 9), 4'hf, 4'h0, '0, lat);
        check_ops(1'b1, line_addr(3, 9), line_addr(5, 9));
        report("plru_victim", e0);
    endtask

    task automatic random_mix();
        int e0;
        int lat;
        int r0;
        cache_pkg::addr_t a;
        e0 = errors;
        r0 = resp_count;
        for (int i = 0; i < 200; i++) begin
            a = line_addr(10 + $urandom_range(0, 5), 3 + 4 * $urandom_range(0, 2))
                + 4 * $urandom_range(0, 7);
            if ($urandom_range(0, 1) == 1) begin
                access(a, 4'h0, 4'($urandom_range(1, 15)), $urandom, lat);
            end else begin
                access(a, 4'hf, 4'h0, '0, lat);
            end
        end
        checks++;
        if (resp_count - r0 != 200) begin
            errors++;
            $display("CHECK FAILED t=%0t ufp_resp count got %0d expected %0d",
                     $time, resp_count - r0, 200);
        end
        report("random_mix", e0);
    endtask

    initial begin
        void'($urandom(32'hf882_e9e4));
        foreach (delays[i]) begin
            delays[i] = $urandom_range(0, max_delay);
        end
        rst       = 1'b1;
        ufp_addr  = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        read_miss_then_hit();
        masked_write_hits();
        dirty_writeback();
        plru_victim();
        random_mix();
        $display("%0d checks, %0d failed", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* cache_sys.f */
+incdir+common
common/cache_pkg.sv
common/cache_array_if.sv
cache/plru_tree.sv
cache/cache_ways.sv
cache/cache_ctrl.sv
cache/cache.sv
testbench/tb_clock.sv
testbench/cache_sva.sv
testbench/cache_tb.sv

/* Bender.yml */
package:
  name: cache_sys

export_include_dirs:
  - common

sources:
  - common/cache_pkg.sv
  - common/cache_array_if.sv
  - cache/plru_tree.sv
  - cache/cache_ways.sv
  - cache/cache_ctrl.sv
  - cache/cache.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/cache_sva.sv
      - testbench/cache_tb.sv
